// File: build.f
hw/isa_pkg.sv
hw/dbg_pkg.sv
hw/fetch.sv
hw/decode.sv
hw/execute.sv
hw/memory.sv
hw/wb.sv
hw/dbg_apb.sv
hw/proc.sv
tb/proc_props.sv
tb/proc_tb.sv

// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module proc_tb -f build.f -Mdir obj_dir
	./obj_dir/Vproc_tb | tee sim.log
	grep -q "All tests passed!" sim.log

clean:
	rm -rf obj_dir sim.log

// File: tb/proc_patterns.txt
// Entry: kind (1 hex digit), offset or dmem address (3), value (4)
// Kinds: 0 new program, 1 instr word, 2 start, 3 wait halt, 4 dmem check, 5 status check,
//        6 write expecting pslverr, 7 read expecting pslverr, 8 register read check, F end
// Arithmetic: add, sub, and, xor, addi
00000000 1000D803 1000402D 1000405A 1000D94C 1000D951 1000D956 1000D95B
100042F0 10008061 10008082 100080A3 100080C4 100080E5 10000000
20000000 30000000 50000001 40010007 40020013 40030008 4004FFF7 4005FFEA
// Load and store with copy to other addresses
00000000 1000D803 10004037 1000404A 10008220 10008A60 10008261 10004385
10008282 10008AA2 100082BE 10000000
20000000 30000000 50000001 400AFFF7 400BFFF7 400CFFFC 4008FFFC
// Countdown loop with bnez, beqz and j
00000000 1000D803 10004025 1000DA4B 1000DA28 1000413F 100069FD 10006101
1000F800 10002002 1000F800 1000F800 10008026 10008047 10006A01 1000F800
100062F0 10000000
20000000 30000000 50000001 40060000 4007000F
// seq and slt on equal, less and greater
00000000 1000D803 1000403D 10004044 1000407D 1000E170 1000E154 1000E958
1000EA3C 1000828C 100082AD 100082CE 100082EF 1000E970 10004245 1000828B
10000000
20000000 30000000 50000001 40100001 40110000 40120001 40130000 40140000
// Illegal opcode stops the core before the second store
00000000 1000D803 10004029 1000404F 10008226 10004023 10001234 10008226
10000000
20000000 30000000 50000003 40150009
// Bus errors during a long run
00000000 1000D803 1000402F 1000D924 1000D924 1000413F 100069FE 10000000
20000000 50000004 600CF800 70180000 601C1234 30000000 50000001 80080007
F0000000

// File: tb/proc_tb.sv
/*
 * Testbench for the 16-bit single-cycle processor
 * Loads programs over APB from the pattern file, runs them and
 * compares data memory, status and bus errors with expected values
 */
`timescale 1ns/10ps

module proc_tb;

   import isa_pkg::*;
   import dbg_pkg::*;

   localparam int MAX_PATTERNS = 256;
   localparam int RUN_TIMEOUT  = 2000;
   localparam int APB_TIMEOUT  = 16;

   logic      clk;
   logic      rst_n;
   logic      psel;
   logic      penable;
   logic      pwrite;
   dbg_addr_t paddr;
   word_t     pwdata;
   word_t     prdata;
   logic      pready;
   logic      pslverr;
   logic      err;
   logic      halt;
   word_t     status;
   int        checks;

   // Entry layout is kind[31:28], offset[27:16], value[15:0]
   logic [31:0] patterns [MAX_PATTERNS];

   proc DUT (.clk, .rst_n, .psel, .penable, .pwrite, .paddr, .pwdata, .prdata,
             .pready, .pslverr, .err, .halt);

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   task automatic stop_with_failure(input string why);
      $display("%s", why);
      $display("Test failures found");
      $fatal(1);
   endtask

   task automatic check_word(input string name, input word_t expected, input word_t actual);
      checks++;
      if (actual !== expected) begin
         stop_with_failure($sformatf("Fail at %0d ns: %s expected %h, got %h",
                                     $time, name, expected, actual));
      end
   endtask

   task automatic check_flag(input string name, input logic expected, input logic actual);
      checks++;
      if (actual !== expected) begin
         stop_with_failure($sformatf("Fail at %0d ns: %s expected %b, got %b",
                                     $time, name, expected, actual));
      end
   endtask

   // STATUS register fields and the halt/err ports must agree
   task automatic check_status(input logic exp_halted, input logic exp_err,
                               input logic exp_running, input word_t value);
      logic [2:0] exp_bits;
      logic [2:0] got_bits;
      exp_bits = {exp_running, exp_err, exp_halted};
      got_bits = {value[STAT_RUN], value[STAT_ERR], value[STAT_HALTED]};
      checks++;
      if (got_bits !== exp_bits) begin
         stop_with_failure($sformatf("Fail at %0d ns: STATUS {running,err,halted} expected %b, got %b",
                                     $time, exp_bits, got_bits));
      end
      check_flag("halt", exp_halted, halt);
      check_flag("err", exp_err, err);
   endtask

   task automatic apb_transfer(input logic write, input dbg_addr_t addr, input word_t wdata,
                               output word_t rdata, output logic slverr);
      int waits;
      @(posedge clk);
      psel    <= 1'b1;
      penable <= 1'b0;
      pwrite  <= write;
      paddr   <= addr;
      pwdata  <= wdata;
      @(posedge clk);
      penable <= 1'b1;
      waits = 0;
      @(negedge clk);
      while (!pready) begin
         if (waits == APB_TIMEOUT) begin
            stop_with_failure("APB access never saw pready before the timeout");
         end
         waits++;
         @(negedge clk);
      end
      rdata  = prdata;
      slverr = pslverr;
      @(posedge clk);
      psel    <= 1'b0;
      penable <= 1'b0;
      // Random idle gap between transfers
      repeat ($urandom % 3) @(posedge clk);
   endtask

   task automatic apb_write(input dbg_addr_t addr, input word_t data);
      word_t rdata;
      logic  slverr;
      apb_transfer(1'b1, addr, data, rdata, slverr);
      check_flag("pslverr", 1'b0, slverr);
   endtask

   task automatic apb_read(input dbg_addr_t addr, output word_t data);
      logic slverr;
      apb_transfer(1'b0, addr, '0, data, slverr);
      check_flag("pslverr", 1'b0, slverr);
   endtask

   task automatic read_dmem(input logic [7:0] addr, output word_t data);
      apb_write(DMEM_ADDR, word_t'(addr));
      apb_read(DMEM_DATA, data);
   endtask

   // Every slot gets a HALT with random low bits, then loading restarts at 0
   task automatic clear_imem();
      int i;
      apb_write(IMEM_ADDR, '0);
      for (i = 0; i < IMEM_WORDS; i++) begin
         apb_write(IMEM_DATA, {5'b00000, 11'($urandom)});
      end
      apb_write(IMEM_ADDR, '0);
   endtask

   task automatic wait_halt();
      int cycles;
      cycles = 0;
      @(negedge clk);
      while (!(halt || err)) begin
         if (cycles == RUN_TIMEOUT) begin
            stop_with_failure("Core did not halt within the run timeout");
         end
         cycles++;
         @(negedge clk);
      end
   endtask

   task automatic run_patterns();
      logic [3:0]  kind;
      logic [11:0] offset;
      word_t       value;
      word_t       rdata;
      logic        slverr;
      int          idx;
      for (idx = 0; idx < MAX_PATTERNS; idx++) begin
         kind   = patterns[idx][31:28];
         offset = patterns[idx][27:16];
         value  = patterns[idx][15:0];
         if (kind == 4'hF) begin
            break;
         end
         case (kind)
            4'h0: clear_imem();
            4'h1: apb_write(IMEM_DATA, value);
            4'h2: apb_write(CTRL, 16'h0001);
            4'h3: wait_halt();
            4'h4: begin
               read_dmem(offset[7:0], rdata);
               check_word($sformatf("dmem[%0d]", offset), value, rdata);
            end
            4'h5: begin
               apb_read(STATUS, rdata);
               check_status(value[STAT_HALTED], value[STAT_ERR], value[STAT_RUN], rdata);
            end
            4'h6: begin
               apb_transfer(1'b1, dbg_addr_t'(offset), value, rdata, slverr);
               check_flag($sformatf("pslverr on write to %h", offset), 1'b1, slverr);
            end
            4'h7: begin
               apb_transfer(1'b0, dbg_addr_t'(offset), '0, rdata, slverr);
               check_flag($sformatf("pslverr on read of %h", offset), 1'b1, slverr);
            end
            4'h8: begin
               apb_read(dbg_addr_t'(offset), rdata);
               check_word($sformatf("APB register %h", offset), value, rdata);
            end
            default: begin
               stop_with_failure($sformatf("Unknown pattern kind %h in entry %0d", kind, idx));
            end
         endcase
      end
      if (idx == MAX_PATTERNS) begin
         stop_with_failure("Pattern list has no end marker");
      end
   endtask

   initial begin
      rst_n   = 1'b0;
      psel    = 1'b0;
      penable = 1'b0;
      pwrite  = 1'b0;
      paddr   = '0;
      pwdata  = '0;
      checks  = 0;
      void'($urandom(78));
      foreach (patterns[i]) begin
         patterns[i] = 32'hF000_0000;
      end
      $readmemh("tb/proc_patterns.txt", patterns);
      repeat (3) @(posedge clk);
      rst_n <= 1'b1;
      // Idle after reset
      apb_read(STATUS, status);
      check_status(1'b0, 1'b0, 1'b0, status);
      run_patterns();
      if (checks < 40) begin
         stop_with_failure("Too few checks ran, the pattern file looks incomplete");
      end else begin
         $display("All tests passed!");
         $finish;
      end
   end

endmodule

// File: tb/proc_props.sv
/*
 * Assertions bound to the APB debug slave
 * Bus response rules and run control after a halt request
 */
`timescale 1ns/10ps

module proc_props (
   input logic clk,
   input logic rst_n,
   input logic psel,
   input logic penable,
   input logic pready,
   input logic pslverr,
   input logic run,
   input logic halt_req
);

   // Zero wait states
   pready_high: assert property (@(posedge clk) disable iff (!rst_n) pready)
      else $error("pready dropped low");

   slverr_in_access: assert property (@(posedge clk) disable iff (!rst_n)
                                      pslverr |-> (psel && penable))
      else $error("pslverr raised outside an access cycle");

   run_stops: assert property (@(posedge clk) disable iff (!rst_n) halt_req |=> !run)
      else $error("run still high after a halt request");

endmodule

bind dbg_apb proc_props props (.clk, .rst_n, .psel, .penable, .pready, .pslverr,
                               .run, .halt_req);

// File: hw/proc.sv
/*
 * 16-bit single-cycle processor top level
 * Joins fetch, decode, execute, memory and writeback with the APB
 * debug slave; err and halt report the trap state
 */
`timescale 1ns/10ps

module proc (
   input  logic               clk,
   input  logic               rst_n,
   input  logic               psel,
   input  logic               penable,
   input  logic               pwrite,
   input  dbg_pkg::dbg_addr_t paddr,
   input  isa_pkg::word_t     pwdata,
   output isa_pkg::word_t     prdata,
   output logic               pready,
   output logic               pslverr,
   output logic               err,
   output logic               halt
);

   import isa_pkg::*;

   // Run control and debug paths
   logic               run, start, halt_req;
   logic               imem_we;
   logic [IMEM_AW-1:0] imem_waddr;
   word_t              imem_wdata;
   logic [DMEM_AW-1:0] dmem_raddr;
   word_t              dbg_rdata;

   // Datapath
   instr_u  instr;
   word_t   pc_inc, br_target, rd_data_1, rd_data_2, imm;
   word_t   alu_out, mem_out, wr_data;
   alu_op_t alu_op;
   wb_src_t wb_src;
   logic    use_imm, br_instr, br_nz, jmp_instr, set_eq, set_lt;
   logic    mem_en, mem_wr, set_bit, take_br;

   fetch fetch_stage (.clk, .rst_n, .run, .start, .take_br, .br_target,
                      .imem_we, .imem_waddr, .imem_wdata, .instr, .pc_inc);

   decode decode_stage (.clk, .rst_n, .run, .instr, .wr_data, .rd_data_1,
                        .rd_data_2, .imm, .alu_op, .use_imm, .br_instr, .br_nz,
                        .jmp_instr, .set_eq, .set_lt, .mem_en, .mem_wr, .wb_src,
                        .halted(halt), .err, .halt_req);

   execute execute_stage (.rd_data_1, .rd_data_2, .imm, .pc_inc, .alu_op, .use_imm,
                          .br_instr, .br_nz, .jmp_instr, .set_eq, .set_lt,
                          .alu_out, .set_bit, .take_br, .br_target);

   memory memory_stage (.clk, .rst_n, .mem_en, .mem_wr, .addr(alu_out),
                        .data_in(rd_data_2), .dmem_raddr, .mem_out, .dbg_rdata);

   wb wb_stage (.wb_src, .alu_out, .mem_out, .set_bit, .wr_data);

   dbg_apb dbg_slave (.clk, .rst_n, .psel, .penable, .pwrite, .paddr, .pwdata,
                      .halted(halt), .err, .halt_req, .dbg_rdata, .prdata,
                      .pready, .pslverr, .run, .start, .imem_we, .imem_waddr,
                      .imem_wdata, .dmem_raddr);

endmodule

// File: hw/dbg_apb.sv
/*
 * APB debug slave, zero wait states
 * Run control, status, instruction loading and data memory readback
 */
`timescale 1ns/10ps

module dbg_apb (
   input  logic                        clk,
   input  logic                        rst_n,
   input  logic                        psel,
   input  logic                        penable,
   input  logic                        pwrite,
   input  dbg_pkg::dbg_addr_t          paddr,
   input  isa_pkg::word_t              pwdata,
   input  logic                        halted,
   input  logic                        err,
   input  logic                        halt_req,
   input  isa_pkg::word_t              dbg_rdata,
   output isa_pkg::word_t              prdata,
   output logic                        pready,
   output logic                        pslverr,
   output logic                        run,
   output logic                        start,
   output logic                        imem_we,
   output logic [isa_pkg::IMEM_AW-1:0] imem_waddr,
   output isa_pkg::word_t              imem_wdata,
   output logic [isa_pkg::DMEM_AW-1:0] dmem_raddr
);

   import isa_pkg::*;
   import dbg_pkg::*;

   logic               access;
   logic               wr;
   logic               mapped;
   logic [IMEM_AW-1:0] imem_ptr;
   logic [DMEM_AW-1:0] dmem_ptr;

   assign access = psel & penable;
   assign wr     = access & pwrite;
   assign mapped = paddr inside {CTRL, STATUS, IMEM_ADDR, IMEM_DATA, DMEM_ADDR, DMEM_DATA};

   assign pready  = 1'b1;
   assign pslverr = access & (!mapped | (pwrite & (paddr == IMEM_DATA) & run));

   // Instruction loads are refused while the core runs
   assign start      = wr & (paddr == CTRL) & pwdata[0];
   assign imem_we    = wr & (paddr == IMEM_DATA) & !run;
   assign imem_waddr = imem_ptr;
   assign imem_wdata = pwdata;
   assign dmem_raddr = dmem_ptr;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         run      <= 1'b0;
         imem_ptr <= '0;
         dmem_ptr <= '0;
      end else begin
         if (halt_req) begin
            run <= 1'b0;
         end else if (wr && paddr == CTRL) begin
            run <= pwdata[0];
         end
         if (wr && paddr == IMEM_ADDR) begin
            imem_ptr <= pwdata[IMEM_AW-1:0];
         end else if (imem_we) begin
            imem_ptr <= imem_ptr + 1'b1;
         end
         if (wr && paddr == DMEM_ADDR) begin
            dmem_ptr <= pwdata[DMEM_AW-1:0];
         end
      end
   end

   // Write-only and unmapped offsets read as zero
   always_comb begin
      prdata = '0;
      case (paddr)
         STATUS: begin
            prdata[STAT_HALTED] = halted;
            prdata[STAT_ERR]    = err;
            prdata[STAT_RUN]    = run;
         end
         IMEM_ADDR: prdata = word_t'(imem_ptr);
         DMEM_ADDR: prdata = word_t'(dmem_ptr);
         DMEM_DATA: prdata = dbg_rdata;
         default:   prdata = '0;
      endcase
   end

endmodule

// File: hw/wb.sv
/*
 * Writeback stage
 * Picks the register write value
 */
`timescale 1ns/10ps

module wb (
   input  isa_pkg::wb_src_t wb_src,
   input  isa_pkg::word_t   alu_out,
   input  isa_pkg::word_t   mem_out,
   input  logic             set_bit,
   output isa_pkg::word_t   wr_data
);

   import isa_pkg::*;

   always_comb begin
      case (wb_src)
         WB_MEM:  wr_data = mem_out;
         WB_SET:  wr_data = {15'd0, set_bit};
         default: wr_data = alu_out;
      endcase
   end

endmodule

// File: hw/memory.sv
/*
 * Memory stage
 * Data memory with a core load/store port and a debug read port
 */
`timescale 1ns/10ps

module memory (
   input  logic                        clk,
   input  logic                        rst_n,
   input  logic                        mem_en,
   input  logic                        mem_wr,
   input  isa_pkg::word_t              addr,
   input  isa_pkg::word_t              data_in,
   input  logic [isa_pkg::DMEM_AW-1:0] dmem_raddr,
   output isa_pkg::word_t              mem_out,
   output isa_pkg::word_t              dbg_rdata
);

   import isa_pkg::*;

   word_t dmem [DMEM_WORDS];
   logic  wr_en;

   // Stores are blocked while reset is asserted
   assign wr_en = rst_n & mem_en & mem_wr;

   always_ff @(posedge clk) begin
      if (wr_en) begin
         dmem[addr[DMEM_AW-1:0]] <= data_in;
      end
   end

   assign mem_out   = mem_en ? dmem[addr[DMEM_AW-1:0]] : '0;
   assign dbg_rdata = dmem[dmem_raddr];

endmodule

// File: hw/execute.sv
/*
 * Execute stage
 * ALU, set-on-compare flags, branch decision and target address
 */
`timescale 1ns/10ps

module execute (
   input  isa_pkg::word_t   rd_data_1,
   input  isa_pkg::word_t   rd_data_2,
   input  isa_pkg::word_t   imm,
   input  isa_pkg::word_t   pc_inc,
   input  isa_pkg::alu_op_t alu_op,
   input  logic             use_imm,
   input  logic             br_instr,
   input  logic             br_nz,
   input  logic             jmp_instr,
   input  logic             set_eq,
   input  logic             set_lt,
   output isa_pkg::word_t   alu_out,
   output logic             set_bit,
   output logic             take_br,
   output isa_pkg::word_t   br_target
);

   import isa_pkg::*;

   word_t       oprnd_2;
   logic [16:0] diff;
   logic        eq;
   logic        lt;
   logic        rs_zero;

   assign oprnd_2 = use_imm ? imm : rd_data_2;

   // One extra sign bit so the compare never overflows
   assign diff = {rd_data_1[15], rd_data_1} - {oprnd_2[15], oprnd_2};
   assign eq   = (diff == 17'd0);
   assign lt   = diff[16];

   always_comb begin
      case (alu_op)
         ALU_ADD: alu_out = rd_data_1 + oprnd_2;
         ALU_SUB: alu_out = diff[15:0];
         ALU_AND: alu_out = rd_data_1 & oprnd_2;
         default: alu_out = rd_data_1 ^ oprnd_2;
      endcase
   end

   assign set_bit = (set_eq & eq) | (set_lt & lt);

   // Branches test rs against zero
   assign rs_zero   = (rd_data_1 == '0);
   assign take_br   = jmp_instr | (br_instr & (br_nz ? !rs_zero : rs_zero));
   assign br_target = pc_inc + imm;

endmodule

// File: hw/decode.sv
/*
 * Decode stage
 * Instruction decoding, control generation, register file and the
 * halt / illegal-opcode trap
 */
`timescale 1ns/10ps

module decode (
   input  logic              clk,
   input  logic              rst_n,
   input  logic              run,
   input  isa_pkg::instr_u   instr,
   input  isa_pkg::word_t    wr_data,
   output isa_pkg::word_t    rd_data_1,
   output isa_pkg::word_t    rd_data_2,
   output isa_pkg::word_t    imm,
   output isa_pkg::alu_op_t  alu_op,
   output logic              use_imm,
   output logic              br_instr,
   output logic              br_nz,
   output logic              jmp_instr,
   output logic              set_eq,
   output logic              set_lt,
   output logic              mem_en,
   output logic              mem_wr,
   output isa_pkg::wb_src_t  wb_src,
   output logic              halted,
   output logic              err,
   output logic              halt_req
);

   import isa_pkg::*;

   word_t    rf [8];
   logic     rf_we;
   reg_idx_t wr_reg;
   logic     is_halt;
   logic     illegal;
   logic     halted_q;
   logic     err_q;

   // rs sits in the same place in every format; [7:5] is rt or the I-format rd
   assign rd_data_1 = rf[instr.r_fmt.rs];
   assign rd_data_2 = rf[instr.r_fmt.rt];

   always_comb begin
      imm       = '0;
      alu_op    = ALU_ADD;
      use_imm   = 1'b0;
      br_instr  = 1'b0;
      br_nz     = 1'b0;
      jmp_instr = 1'b0;
      set_eq    = 1'b0;
      set_lt    = 1'b0;
      mem_en    = 1'b0;
      mem_wr    = 1'b0;
      wb_src    = WB_ALU;
      rf_we     = 1'b0;
      wr_reg    = instr.r_fmt.rd;
      is_halt   = 1'b0;
      illegal   = 1'b0;
      if (run) begin
         case (instr.r_fmt.opcode)
            OP_RTYPE: begin
               alu_op = instr.r_fmt.funct;
               rf_we  = 1'b1;
            end
            OP_ADDI, OP_LD, OP_ST: begin
               imm     = {{11{instr.i_fmt.imm[4]}}, instr.i_fmt.imm};
               use_imm = 1'b1;
               wr_reg  = instr.i_fmt.rd;
               mem_en  = (instr.i_fmt.opcode != OP_ADDI);
               mem_wr  = (instr.i_fmt.opcode == OP_ST);
               rf_we   = (instr.i_fmt.opcode != OP_ST);
               wb_src  = (instr.i_fmt.opcode == OP_LD) ? WB_MEM : WB_ALU;
            end
            OP_BEQZ, OP_BNEZ: begin
               imm      = {{8{instr.b_fmt.disp[7]}}, instr.b_fmt.disp};
               br_instr = 1'b1;
               br_nz    = (instr.b_fmt.opcode == OP_BNEZ);
            end
            OP_J: begin
               imm       = {{5{instr.b_fmt.rs[2]}}, instr.b_fmt.rs, instr.b_fmt.disp};
               jmp_instr = 1'b1;
            end
            OP_SEQ, OP_SLT: begin
               alu_op = ALU_SUB;
               set_eq = (instr.r_fmt.opcode == OP_SEQ);
               set_lt = (instr.r_fmt.opcode == OP_SLT);
               wb_src = WB_SET;
               rf_we  = 1'b1;
            end
            OP_HALT: is_halt = 1'b1;
            default: illegal = 1'b1;
         endcase
      end
   end

   assign halt_req = is_halt | illegal;

   // No reset, contents are undefined until written
   always_ff @(posedge clk) begin
      if (rf_we) begin
         rf[wr_reg] <= wr_data;
      end
   end

   // Stop state, refreshed on every running cycle
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         halted_q <= 1'b0;
         err_q    <= 1'b0;
      end else if (run) begin
         halted_q <= halt_req;
         err_q    <= illegal;
      end
   end

   // A start raises run, which clears the previous stop state at once
   assign halted = halted_q & !run;
   assign err    = err_q & !run;

endmodule

// File: hw/fetch.sv
/*
 * Fetch stage
 * Program counter, instruction memory and next-PC selection
 */
`timescale 1ns/10ps

module fetch (
   input  logic                        clk,
   input  logic                        rst_n,
   input  logic                        run,
   input  logic                        start,
   input  logic                        take_br,
   input  isa_pkg::word_t              br_target,
   input  logic                        imem_we,
   input  logic [isa_pkg::IMEM_AW-1:0] imem_waddr,
   input  isa_pkg::word_t              imem_wdata,
   output isa_pkg::instr_u             instr,
   output isa_pkg::word_t              pc_inc
);

   import isa_pkg::*;

   word_t pc;
   word_t imem [IMEM_WORDS];

   // Start wins over a running update
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         pc <= '0;
      end else if (start) begin
         pc <= '0;
      end else if (run) begin
         pc <= take_br ? br_target : pc_inc;
      end
   end

   // Loaded only through the debug slave
   always_ff @(posedge clk) begin
      if (imem_we) begin
         imem[imem_waddr] <= imem_wdata;
      end
   end

   assign instr  = imem[pc[IMEM_AW-1:0]];
   assign pc_inc = pc + 16'd1;

endmodule

// File: hw/dbg_pkg.sv
/*
 * Debug slave register map
 * APB offsets and STATUS bit positions
 */
package dbg_pkg;

   typedef logic [4:0] dbg_addr_t;

   localparam dbg_addr_t CTRL      = 5'h00;
   localparam dbg_addr_t STATUS    = 5'h04;
   localparam dbg_addr_t IMEM_ADDR = 5'h08;
   localparam dbg_addr_t IMEM_DATA = 5'h0C;
   localparam dbg_addr_t DMEM_ADDR = 5'h10;
   localparam dbg_addr_t DMEM_DATA = 5'h14;

   // STATUS bits
   localparam int STAT_HALTED = 0;
   localparam int STAT_ERR    = 1;
   localparam int STAT_RUN    = 2;

endpackage

// File: hw/isa_pkg.sv
/*
 * ISA definitions for the 16-bit single-cycle core
 * Machine widths, opcodes, ALU function codes and instruction formats
 */
package isa_pkg;

   typedef logic [15:0] word_t;
   typedef logic [2:0]  reg_idx_t;

   // Memory sizes in words
   localparam int IMEM_WORDS = 256;
   localparam int DMEM_WORDS = 256;
   localparam int IMEM_AW    = $clog2(IMEM_WORDS);
   localparam int DMEM_AW    = $clog2(DMEM_WORDS);

   // Anything not listed here is illegal
   typedef enum logic [4:0] {
      OP_HALT  = 5'b00000,
      OP_J     = 5'b00100,
      OP_ADDI  = 5'b01000,
      OP_BEQZ  = 5'b01100,
      OP_BNEZ  = 5'b01101,
      OP_ST    = 5'b10000,
      OP_LD    = 5'b10001,
      OP_RTYPE = 5'b11011,
      OP_SEQ   = 5'b11100,
      OP_SLT   = 5'b11101
   } opcode_t;

   // Also the function field of R-format words
   typedef enum logic [1:0] {
      ALU_ADD = 2'd0,
      ALU_SUB = 2'd1,
      ALU_AND = 2'd2,
      ALU_XOR = 2'd3
   } alu_op_t;

   typedef enum logic [1:0] {
      WB_ALU = 2'd0,
      WB_MEM = 2'd1,
      WB_SET = 2'd2
   } wb_src_t;

   typedef struct packed {
      opcode_t  opcode;
      reg_idx_t rs;
      reg_idx_t rt;
      reg_idx_t rd;
      alu_op_t  funct;
   } r_fmt_t;

   typedef struct packed {
      opcode_t    opcode;
      reg_idx_t   rs;
      reg_idx_t   rd;
      logic [4:0] imm;
   } i_fmt_t;

   // Jump takes {rs, disp} as an 11-bit displacement
   typedef struct packed {
      opcode_t    opcode;
      reg_idx_t   rs;
      logic [7:0] disp;
   } b_fmt_t;

   typedef union packed {
      r_fmt_t r_fmt;
      i_fmt_t i_fmt;
      b_fmt_t b_fmt;
   } instr_u;

endpackage
